/* hdl/matvec_pkg.sv */
`default_nettype none

package matvec_pkg;

    // matrix dimension, also the vector length
    localparam int vec_len = 3;

    // row-major matrix words loaded ahead of the vector
    localparam int mat_words = 9;

    // data widths
    localparam int sample_width = 14;
    localparam int result_width = 28;

    // address widths of the two coefficient memories
    localparam int w_addr_width = 4;
    localparam int x_addr_width = 2;

    typedef logic signed [sample_width-1:0] sample_t;
    typedef logic signed [result_width-1:0] result_t;
    typedef logic [w_addr_width-1:0] w_addr_t;
    typedef logic [x_addr_width-1:0] x_addr_t;

    // one write port of a coefficient memory
    // vector memory only decodes the low address bits
    typedef struct packed {
        logic    en;
        w_addr_t addr;
        sample_t data;
    } coef_wr_t;

    // per-cycle controls of the multiply-accumulate
    typedef struct packed {
        logic en_product;
        logic en_acc;
        logic clear_acc;
    } mac_ctrl_t;

endpackage

`default_nettype wire

/* hdl/coef_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module coef_memory
    import matvec_pkg::*;
#(
    parameter int depth = 9
) (
    input  logic     clk,
    input  coef_wr_t wr,
    input  w_addr_t  rd_addr,
    output sample_t  rd_data
);

    // coefficient storage, no reset on the array
    sample_t mem [depth];

    // write port
    // only enough low address bits to cover depth are decoded
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr[$clog2(depth)-1:0]] <= wr.data;
        end
    end

    // read port, one cycle latency
    // data follows rd_addr every cycle, no read enable
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr[$clog2(depth)-1:0]];
    end

    // load sequencer must keep writes inside the array
    // matters most for the short vector instance
    wr_addr_in_range: assert property (
        @(posedge clk) wr.en |-> (int'(wr.addr) < depth)
    ) else $error("coef_memory write address %0d beyond depth %0d", wr.addr, depth);

endmodule

`default_nettype wire

/* hdl/load_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module load_sequencer
    import matvec_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     input_valid,
    input  sample_t  input_data,
    input  logic     rows_done,
    output logic     input_ready,
    output coef_wr_t w_wr,
    output coef_wr_t x_wr,
    output logic     load_done
);

    // high while the port takes matrix and vector words
    logic    loading;

    // index of the next word from 0 to 11
    w_addr_t word_cnt;

    logic    accept;
    logic    last_word;
    logic    to_matrix;

    assign input_ready = loading;

    // handshake on this edge
    assign accept = input_valid && loading;

    // twelfth word closes the load
    assign last_word = (word_cnt == w_addr_t'(mat_words + vec_len - 1));

    // first nine words are the row-major matrix
    assign to_matrix = (word_cnt < w_addr_t'(mat_words));

    // steer the accepted word onto the write ports
    // written on the same edge that accepts it
    always_comb begin
        w_wr.en   = accept && to_matrix;
        w_wr.addr = word_cnt;
        w_wr.data = input_data;
        // vector index is the word position past the matrix
        x_wr.en   = accept && !to_matrix;
        x_wr.addr = word_cnt - w_addr_t'(mat_words);
        x_wr.data = input_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            loading   <= 1'b1;
            word_cnt  <= '0;
            load_done <= 1'b0;
        end else begin
            // single-cycle pulse
            load_done <= 1'b0;
            if (accept) begin
                if (last_word) begin
                    // hand over to the row sequencer
                    loading   <= 1'b0;
                    word_cnt  <= '0;
                    load_done <= 1'b1;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end else if (rows_done) begin
                // all three results taken so the port reopens
                loading <= 1'b1;
            end
        end
    end

    // rows only finish after a complete load
    rows_done_after_load: assert property (
        @(posedge clk) disable iff (reset)
        rows_done |-> !input_ready
    ) else $error("rows_done arrived while the load port was open");

endmodule

`default_nettype wire

/* hdl/row_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module row_sequencer
    import matvec_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      load_done,
    input  logic      output_ready,
    output w_addr_t   w_rd_addr,
    output x_addr_t   x_rd_addr,
    output mac_ctrl_t mac_ctrl,
    output logic      output_valid,
    output logic      rows_done
);

    // tag that follows one term down the pipe
    typedef struct packed {
        logic valid;
        logic first;
        logic last;
    } term_tag_t;

    // current row and column of the issue side
    logic [1:0] row;
    x_addr_t    col;

    // addresses of the current row are going out
    logic       issuing;

    logic       last_col;
    logic       last_row;
    logic       transfer;

    // term tags: issue cycle, memory data stage, product stage
    term_tag_t  issue_tag;
    term_tag_t  rd_tag;
    term_tag_t  prod_tag;

    // last term of the row has just been accumulated
    logic       acc_last;

    assign last_col = (col == x_addr_t'(vec_len - 1));
    assign last_row = (row == 2'(vec_len - 1));
    assign transfer = output_valid && output_ready;

    // matrix index is row*3 + col, vector index is col
    assign w_rd_addr = w_addr_t'(row) * w_addr_t'(vec_len) + w_addr_t'(col);
    assign x_rd_addr = col;

    always_comb begin
        issue_tag.valid = issuing;
        issue_tag.first = issuing && (col == '0);
        issue_tag.last  = issuing && last_col;
    end

    // memory data is valid one cycle behind the address
    // product one more, accumulate one more
    // first term of a row replaces the old sum
    always_comb begin
        mac_ctrl.en_product = rd_tag.valid;
        mac_ctrl.en_acc     = prod_tag.valid;
        mac_ctrl.clear_acc  = prod_tag.valid && prod_tag.first;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            row          <= '0;
            col          <= '0;
            issuing      <= 1'b0;
            rd_tag       <= '0;
            prod_tag     <= '0;
            acc_last     <= 1'b0;
            output_valid <= 1'b0;
            rows_done    <= 1'b0;
        end else begin
            rd_tag    <= issue_tag;
            prod_tag  <= rd_tag;
            acc_last  <= prod_tag.valid && prod_tag.last;
            rows_done <= 1'b0;

            // three column addresses on consecutive cycles
            if (issuing) begin
                if (last_col) begin
                    issuing <= 1'b0;
                    col     <= '0;
                end else begin
                    col <= col + 1'b1;
                end
            end

            // fresh matrix and vector, start at row 0
            if (load_done) begin
                issuing <= 1'b1;
            end

            // issue waits here for the result to be taken,
            // so back-pressure freezes the whole pipe
            if (transfer) begin
                output_valid <= 1'b0;
                if (last_row) begin
                    row       <= '0;
                    rows_done <= 1'b1;
                end else begin
                    row     <= row + 1'b1;
                    issuing <= 1'b1;
                end
            end else if (acc_last) begin
                output_valid <= 1'b1;
            end
        end
    end

    // result held until the consumer takes it
    valid_held: assert property (
        @(posedge clk) disable iff (reset)
        output_valid && !output_ready |=> output_valid
    ) else $error("output_valid dropped before output_ready");

    // pending result: no new addresses, accumulator frozen
    idle_while_pending: assert property (
        @(posedge clk) disable iff (reset)
        output_valid |-> !issuing && !mac_ctrl.en_acc
    ) else $error("address issued while a result is pending");

endmodule

`default_nettype wire

/* hdl/mac_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_unit
    import matvec_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  mac_ctrl_t mac_ctrl,
    input  sample_t   w_data,
    input  sample_t   x_data,
    output result_t   acc_value
);

    // product pipeline register
    result_t product;

    // running sum of the current row
    result_t acc;

    assign acc_value = acc;

    // full 28-bit signed product, max neg squared still fits
    always_ff @(posedge clk) begin
        if (mac_ctrl.en_product) begin
            product <= w_data * x_data;
        end
    end

    // sum wraps modulo 2^28
    // clear with add starts a new row from the product alone
    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
        end else begin
            case ({mac_ctrl.clear_acc, mac_ctrl.en_acc})
                2'b11: begin
                    acc <= product;
                end
                2'b10: begin
                    acc <= '0;
                end
                2'b01: begin
                    acc <= acc + product;
                end
                default: begin
                    // hold, also while the result waits
                    acc <= acc;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/matvec3.sv */
`timescale 1ns/1ps
`default_nettype none

module matvec3
    import matvec_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    input_valid,
    output logic    input_ready,
    input  sample_t input_data,
    output logic    output_valid,
    input  logic    output_ready,
    output result_t output_data
);

    // memory write ports from the loader
    coef_wr_t  w_wr;
    coef_wr_t  x_wr;

    // handover between the two sequencers
    logic      load_done;
    logic      rows_done;

    // read side
    w_addr_t   w_rd_addr;
    x_addr_t   x_rd_addr;
    sample_t   w_data;
    sample_t   x_data;

    mac_ctrl_t mac_ctrl;

    load_sequencer load_seq_i (
        .clk         (clk),
        .reset       (reset),
        .input_valid (input_valid),
        .input_data  (input_data),
        .rows_done   (rows_done),
        .input_ready (input_ready),
        .w_wr        (w_wr),
        .x_wr        (x_wr),
        .load_done   (load_done)
    );

    row_sequencer row_seq_i (
        .clk          (clk),
        .reset        (reset),
        .load_done    (load_done),
        .output_ready (output_ready),
        .w_rd_addr    (w_rd_addr),
        .x_rd_addr    (x_rd_addr),
        .mac_ctrl     (mac_ctrl),
        .output_valid (output_valid),
        .rows_done    (rows_done)
    );

    // 3x3 matrix, row-major
    coef_memory #(.depth(mat_words)) matrix_mem (
        .clk     (clk),
        .wr      (w_wr),
        .rd_addr (w_rd_addr),
        .rd_data (w_data)
    );

    // vector, zero-extended read address
    coef_memory #(.depth(vec_len)) vector_mem (
        .clk     (clk),
        .wr      (x_wr),
        .rd_addr (w_addr_t'(x_rd_addr)),
        .rd_data (x_data)
    );

    mac_unit mac_i (
        .clk       (clk),
        .reset     (reset),
        .mac_ctrl  (mac_ctrl),
        .w_data    (w_data),
        .x_data    (x_data),
        .acc_value (output_data)
    );

endmodule

`default_nettype wire

/* bench/matvec3_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module matvec3_tb
    import matvec_pkg::*;
();

    // one table row: operands, handshake pacing and expected rows
    typedef struct packed {
        sample_t [mat_words-1:0] mat;
        sample_t [vec_len-1:0]   vec;
        logic [3:0]              gap_max;
        logic [3:0]              stall_max;
        result_t [vec_len-1:0]   expected;
    } entry_t;

    localparam int num_entries = 8;
    localparam int num_directed = 3;
    // cycles per input word at worst, gap plus accept
    localparam int max_word_cycles = 4;
    localparam int max_stall = 5;
    localparam int cycle_limit =
        num_entries * (12 * max_word_cycles + 3 * (6 + max_stall)) * 2;

    logic    clk;
    logic    reset;
    logic    input_valid;
    logic    input_ready;
    sample_t input_data;
    logic    output_valid;
    logic    output_ready;
    result_t output_data;

    entry_t  tests [num_entries];
    int      errors = 0;
    int      cycles = 0;

    matvec3 dut_i (
        .clk          (clk),
        .reset        (reset),
        .input_valid  (input_valid),
        .input_ready  (input_ready),
        .input_data   (input_data),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .output_data  (output_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // watchdog on total run length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not complete within %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input longint actual, input longint expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            errors++;
        end
    endtask

    // reference model: row dot product, wrapped to 28 signed bits
    function automatic result_t row_sum(input entry_t e, input int r);
        int sum;
        int w;
        int x;
        sum = 0;
        for (int c = 0; c < vec_len; c++) begin
            w = int'(e.mat[r * vec_len + c]);
            x = int'(e.vec[c]);
            sum = sum + w * x;
        end
        return result_t'(sum);
    endfunction

    task automatic fill_table();
        // all zero, no pacing
        tests[0] = '0;
        // identity, passes the vector through
        tests[1] = '0;
        tests[1].mat[0] = sample_t'(1);
        tests[1].mat[4] = sample_t'(1);
        tests[1].mat[8] = sample_t'(1);
        tests[1].vec[0] = sample_t'(5);
        tests[1].vec[1] = sample_t'(-7);
        tests[1].vec[2] = sample_t'(100);
        tests[1].gap_max = 4'd2;
        tests[1].stall_max = 4'd3;
        tests[1].expected[0] = result_t'(5);
        tests[1].expected[1] = result_t'(-7);
        tests[1].expected[2] = result_t'(100);
        // max neg squared three times, 3 * 2^26 wraps negative
        tests[2] = '0;
        for (int k = 0; k < mat_words; k++) begin
            tests[2].mat[k] = sample_t'(-8192);
        end
        for (int k = 0; k < vec_len; k++) begin
            tests[2].vec[k] = sample_t'(-8192);
            tests[2].expected[k] = result_t'(-67108864);
        end
        tests[2].stall_max = 4'd1;
        // random operands, expected rows from the model
        for (int i = num_directed; i < num_entries; i++) begin
            for (int k = 0; k < mat_words; k++) begin
                tests[i].mat[k] = sample_t'($urandom);
            end
            for (int k = 0; k < vec_len; k++) begin
                tests[i].vec[k] = sample_t'($urandom);
            end
            tests[i].gap_max = 4'($urandom_range(0, max_word_cycles - 1));
            tests[i].stall_max = 4'($urandom_range(0, max_stall - 1));
            for (int r = 0; r < vec_len; r++) begin
                tests[i].expected[r] = row_sum(tests[i], r);
            end
        end
    endtask

    // twelve words, random idle cycles ahead of each
    // called on a falling edge, returns on one
    task automatic load_entry(input entry_t e);
        int gap;
        for (int i = 0; i < mat_words + vec_len; i++) begin
            gap = int'($urandom_range(0, e.gap_max));
            repeat (gap) begin
                input_valid = 1'b0;
                @(negedge clk);
            end
            input_valid = 1'b1;
            input_data = (i < mat_words) ? e.mat[i] : e.vec[i - mat_words];
            // input_ready is stable at the falling edge
            while (!input_ready) begin
                @(negedge clk);
            end
            @(negedge clk);
        end
        input_valid = 1'b0;
    endtask

    // take three results under random stalls, junk on the input side
    task automatic collect_results(input entry_t e);
        int      stall;
        logic    seen;
        logic    done;
        result_t held;
        for (int r = 0; r < vec_len; r++) begin
            stall = int'($urandom_range(0, e.stall_max));
            seen = 1'b0;
            done = 1'b0;
            while (!done) begin
                // junk words must be ignored while the port is closed
                if (!input_ready) begin
                    input_valid = 1'b1;
                    input_data = sample_t'($urandom);
                end else begin
                    input_valid = 1'b0;
                end
                if (output_valid) begin
                    if (!seen) begin
                        held = output_data;
                        seen = 1'b1;
                    end else begin
                        check_value("output_data while stalled", longint'(output_data),
                                    longint'(held));
                    end
                    if (stall > 0) begin
                        output_ready = 1'b0;
                        stall--;
                        @(negedge clk);
                    end else begin
                        check_value($sformatf("output_data row %0d", r),
                                    longint'(output_data), longint'(e.expected[r]));
                        output_ready = 1'b1;
                        @(negedge clk);
                        output_ready = 1'b0;
                        // a repeated result would still show valid here
                        check_value("output_valid after transfer", longint'(output_valid), 0);
                        done = 1'b1;
                    end
                end else begin
                    if (seen) begin
                        $display("Error at %0t: output_valid dropped before row %0d was taken",
                                 $time, r);
                        errors++;
                        done = 1'b1;
                    end
                    output_ready = 1'b0;
                    @(negedge clk);
                end
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        input_valid = 1'b0;
        input_data = '0;
        output_ready = 1'b0;
        void'($urandom(32'hb624));
        fill_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("input_ready after reset", longint'(input_ready), 1);
        check_value("output_valid after reset", longint'(output_valid), 0);
        for (int i = 0; i < num_entries; i++) begin
            load_entry(tests[i]);
            check_value("input_ready after load", longint'(input_ready), 0);
            collect_results(tests[i]);
            // rows_done pulse, then the load port reopens
            @(negedge clk);
            input_valid = 1'b0;
            check_value("input_ready after third result", longint'(input_ready), 1);
        end
        $display("Checks complete: %0d errors over %0d entries", errors, num_entries);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* matvec3.f */
hdl/matvec_pkg.sv
hdl/coef_memory.sv
hdl/load_sequencer.sv
hdl/row_sequencer.sv
hdl/mac_unit.sv
hdl/matvec3.sv
bench/matvec3_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the matvec3 testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --assert -f matvec3.f --top-module matvec3_tb -Mdir "$obj"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$obj/Vmatvec3_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$log"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi
